/* rtl/rv32iPkg.sv */
package rv32iPkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int xlen = 32;               // data path and PC width
	localparam int regAddrW = 5;            // register index width
	localparam int numRegs = 1 << regAddrW; // architectural registers, x0 included
	localparam int shamtW = 5;              // shift amount comes from the low bits of operand b

	////////////////////////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////////////////////////

	// major opcodes handled by this execute subsystem, everything else is illegal
	typedef enum logic [6:0] {
		opcOp    = 7'b0110011, // register-register arithmetic
		opcOpImm = 7'b0010011, // register-immediate arithmetic
		opcLui   = 7'b0110111, // load upper immediate
		opcAuipc = 7'b0010111, // add upper immediate to pc
		opcBranch = 7'b1100011 // conditional branches
	} opcodeE;

	// funct3 of OP and OP-IMM
	localparam logic [2:0] f3AddSub = 3'b000; // add, addi, sub
	localparam logic [2:0] f3Sll    = 3'b001; // shift left
	localparam logic [2:0] f3Slt    = 3'b010; // signed set-less-than
	localparam logic [2:0] f3Sltu   = 3'b011; // unsigned set-less-than
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101; // right shifts, funct7 picks the kind
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// funct3 of BRANCH, 010 and 011 are reserved
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	localparam logic [6:0] f7Base = 7'b0000000; // plain variant
	localparam logic [6:0] f7Alt  = 7'b0100000; // sub and arithmetic shift right

	////////////////////////////////////////////////////////////
	// control fields
	////////////////////////////////////////////////////////////

	// low control nibble of the ALU, selects the arithmetic function
	typedef enum logic [3:0] {
		aluAnd,
		aluOr,
		aluAdd,
		aluSub,
		aluSlt,
		aluSltu,
		aluSrl,
		aluSra,
		aluSll,
		aluXor,
		aluPassB // hands operand b through, used by lui
	} aluOpE;

	// high control field of the ALU, selects the branch condition
	typedef enum logic [2:0] {
		brNone, // not a branch, branchEnable stays low
		brBeq,
		brBne,
		brBlt,
		brBge,
		brBltu,
		brBgeu
	} branchOpE;

	// source of ALU operand a
	typedef enum logic {
		srcARs1, // register rs1
		srcAPc   // program counter, for auipc
	} srcASelE;

endpackage

/* rtl/instDecode.sv */
`timescale 1ns/1ps

module instDecode (
	input  logic [31:0]                     instr,
	output logic [rv32iPkg::regAddrW-1:0]   rs1,
	output logic [rv32iPkg::regAddrW-1:0]   rs2,
	output logic [rv32iPkg::regAddrW-1:0]   rd,
	output rv32iPkg::aluOpE                 aluOp,
	output rv32iPkg::branchOpE              branchOp,
	output rv32iPkg::srcASelE               srcASel,
	output logic                            useImm,
	output logic [rv32iPkg::xlen-1:0]       imm,
	output logic                            writesRd,
	output logic                            illegal
);

	logic [6:0] opcode; // major opcode field
	logic [2:0] funct3; // minor function field
	logic [6:0] funct7; // selects sub and sra
	logic [rv32iPkg::xlen-1:0] immI; // sign-extended 12-bit immediate
	logic [rv32iPkg::xlen-1:0] immU; // upper 20 bits, low 12 cleared
	logic [rv32iPkg::xlen-1:0] immB; // branch offset, always even

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign rs1 = instr[19:15]; // register indices sit at fixed positions in every format
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immU = {instr[31:12], 12'b0};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	////////////////////////////////////////////////////////////
	// arithmetic function from funct3, shared by OP and OP-IMM
	////////////////////////////////////////////////////////////

	function automatic rv32iPkg::aluOpE arithOp(input logic [2:0] f3, input logic alt);
		case (f3)
			rv32iPkg::f3AddSub: arithOp = alt ? rv32iPkg::aluSub : rv32iPkg::aluAdd;
			rv32iPkg::f3Sll:    arithOp = rv32iPkg::aluSll;
			rv32iPkg::f3Slt:    arithOp = rv32iPkg::aluSlt;
			rv32iPkg::f3Sltu:   arithOp = rv32iPkg::aluSltu;
			rv32iPkg::f3Xor:    arithOp = rv32iPkg::aluXor;
			rv32iPkg::f3SrlSra: arithOp = alt ? rv32iPkg::aluSra : rv32iPkg::aluSrl;
			rv32iPkg::f3Or:     arithOp = rv32iPkg::aluOr;
			default:            arithOp = rv32iPkg::aluAnd; // only f3And is left
		endcase
	endfunction

	always_comb begin
		aluOp    = rv32iPkg::aluAdd; // harmless defaults for anything not decoded below
		branchOp = rv32iPkg::brNone;
		srcASel  = rv32iPkg::srcARs1;
		useImm   = 1'b0;
		imm      = immI;
		writesRd = 1'b0;
		illegal  = 1'b0;

		case (opcode)
			rv32iPkg::opcOp: begin
				aluOp    = arithOp(funct3, funct7 == rv32iPkg::f7Alt); // alt only means sub or sra
				writesRd = 1'b1;
				if (funct7 == rv32iPkg::f7Alt) begin
					illegal = (funct3 != rv32iPkg::f3AddSub) && (funct3 != rv32iPkg::f3SrlSra);
				end else begin
					illegal = (funct7 != rv32iPkg::f7Base);
				end
			end
			rv32iPkg::opcOpImm: begin
				// subi does not exist, so alt only counts for the right shifts
				aluOp    = arithOp(funct3, (funct3 == rv32iPkg::f3SrlSra) &&
				                           (funct7 == rv32iPkg::f7Alt));
				useImm   = 1'b1;
				writesRd = 1'b1;
				if (funct3 == rv32iPkg::f3Sll) begin
					illegal = (funct7 != rv32iPkg::f7Base); // slli has no alternate form
				end else if (funct3 == rv32iPkg::f3SrlSra) begin
					illegal = (funct7 != rv32iPkg::f7Base) && (funct7 != rv32iPkg::f7Alt);
				end
			end
			rv32iPkg::opcLui: begin
				aluOp    = rv32iPkg::aluPassB; // result is the immediate itself
				useImm   = 1'b1;
				imm      = immU;
				writesRd = 1'b1;
			end
			rv32iPkg::opcAuipc: begin
				aluOp    = rv32iPkg::aluAdd;
				srcASel  = rv32iPkg::srcAPc; // pc plus upper immediate
				useImm   = 1'b1;
				imm      = immU;
				writesRd = 1'b1;
			end
			rv32iPkg::opcBranch: begin
				aluOp = rv32iPkg::aluSub; // compares rs1 against rs2
				imm   = immB;             // feeds the target adder, not the ALU
				case (funct3)
					rv32iPkg::f3Beq:  branchOp = rv32iPkg::brBeq;
					rv32iPkg::f3Bne:  branchOp = rv32iPkg::brBne;
					rv32iPkg::f3Blt:  branchOp = rv32iPkg::brBlt;
					rv32iPkg::f3Bge:  branchOp = rv32iPkg::brBge;
					rv32iPkg::f3Bltu: branchOp = rv32iPkg::brBltu;
					rv32iPkg::f3Bgeu: branchOp = rv32iPkg::brBgeu;
					default:          illegal  = 1'b1; // reserved branch encodings
				endcase
			end
			default: illegal = 1'b1; // loads, stores, jumps, system and fence
		endcase
	end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  rv32iPkg::aluOpE             aluCtl,
	input  rv32iPkg::branchOpE          branchOp,
	input  logic [rv32iPkg::xlen-1:0]   a,
	input  logic [rv32iPkg::xlen-1:0]   b,
	output logic [rv32iPkg::xlen-1:0]   aluOut,
	output logic                        branchEnable
);

	logic [rv32iPkg::shamtW-1:0] shamt; // only the low bits of b shift

	assign shamt = b[rv32iPkg::shamtW-1:0];

	////////////////////////////////////////////////////////////
	// arithmetic function
	////////////////////////////////////////////////////////////

	always_comb begin
		case (aluCtl)
			rv32iPkg::aluAnd:   aluOut = a & b;
			rv32iPkg::aluOr:    aluOut = a | b;
			rv32iPkg::aluAdd:   aluOut = a + b;  // also addi and auipc
			rv32iPkg::aluSub:   aluOut = a - b;  // also every branch
			rv32iPkg::aluSlt:   aluOut = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv32iPkg::aluSltu:  aluOut = (a < b) ? 32'd1 : 32'd0;
			rv32iPkg::aluSrl:   aluOut = a >> shamt;
			rv32iPkg::aluSra:   aluOut = $signed(a) >>> shamt; // sign bit fills from the left
			rv32iPkg::aluSll:   aluOut = a << shamt;
			rv32iPkg::aluXor:   aluOut = a ^ b;
			rv32iPkg::aluPassB: aluOut = b;      // lui carries its value in b
			default:            aluOut = '0;     // unused encodings
		endcase
	end

	////////////////////////////////////////////////////////////
	// branch condition
	////////////////////////////////////////////////////////////

	always_comb begin
		case (branchOp)
			rv32iPkg::brBeq:  branchEnable = (a == b);
			rv32iPkg::brBne:  branchEnable = (a != b);
			rv32iPkg::brBlt:  branchEnable = ($signed(a) < $signed(b));
			rv32iPkg::brBge:  branchEnable = ($signed(a) >= $signed(b));
			rv32iPkg::brBltu: branchEnable = (a < b);  // plain logic vectors compare unsigned
			rv32iPkg::brBgeu: branchEnable = (a >= b);
			default:          branchEnable = 1'b0;     // brNone and unused codes never branch
		endcase
	end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic [rv32iPkg::regAddrW-1:0]   rdAddr1,
	input  logic [rv32iPkg::regAddrW-1:0]   rdAddr2,
	output logic [rv32iPkg::xlen-1:0]       rdData1,
	output logic [rv32iPkg::xlen-1:0]       rdData2,
	input  logic                            wrEn,
	input  logic [rv32iPkg::regAddrW-1:0]   wrAddr,
	input  logic [rv32iPkg::xlen-1:0]       wrData
);

	// x0 has no storage, so the array starts at index 1
	logic [rv32iPkg::xlen-1:0] regs [1:rv32iPkg::numRegs-1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < rv32iPkg::numRegs; i++) begin
				regs[i] <= '0; // every register starts at zero
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData; // writes to x0 are dropped
		end
	end

	// reads are combinational and see the old value during a same-cycle write
	assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
	assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            inValid,
	input  logic [rv32iPkg::xlen-1:0]       inPc,
	input  logic [rv32iPkg::regAddrW-1:0]   rs1,
	input  logic [rv32iPkg::regAddrW-1:0]   rs2,
	input  logic [rv32iPkg::regAddrW-1:0]   rd,
	input  rv32iPkg::aluOpE                 aluOp,
	input  rv32iPkg::branchOpE              branchOp,
	input  rv32iPkg::srcASelE               srcASel,
	input  logic                            useImm,
	input  logic [rv32iPkg::xlen-1:0]       imm,
	input  logic                            writesRd,
	input  logic                            illegal,
	input  logic [rv32iPkg::xlen-1:0]       rdData1,
	input  logic [rv32iPkg::xlen-1:0]       rdData2,
	output logic                            wrEn,
	output logic [rv32iPkg::regAddrW-1:0]   wrAddr,
	output logic [rv32iPkg::xlen-1:0]       wrData,
	output logic                            resValid,
	output logic [rv32iPkg::regAddrW-1:0]   resRd,
	output logic [rv32iPkg::xlen-1:0]       resData,
	output logic                            resBranch,
	output logic [rv32iPkg::xlen-1:0]       resTarget,
	output logic                            resIllegal
);

	////////////////////////////////////////////////////////////
	// decode-to-execute register
	////////////////////////////////////////////////////////////

	logic                            exValid;    // execute stage holds an instruction
	logic [rv32iPkg::xlen-1:0]       exPc;
	logic [rv32iPkg::regAddrW-1:0]   exRd;
	rv32iPkg::aluOpE                 exAluOp;
	rv32iPkg::branchOpE              exBranchOp;
	rv32iPkg::srcASelE               exSrcASel;
	logic                            exUseImm;
	logic [rv32iPkg::xlen-1:0]       exImm;
	logic                            exWritesRd;
	logic                            exIllegal;
	logic [rv32iPkg::xlen-1:0]       exRs1Data;  // operand values after forwarding
	logic [rv32iPkg::xlen-1:0]       exRs2Data;

	logic                            fwdHit;     // execute result will land in a real register
	logic [rv32iPkg::xlen-1:0]       fwdData1;
	logic [rv32iPkg::xlen-1:0]       fwdData2;
	logic [rv32iPkg::xlen-1:0]       opA;
	logic [rv32iPkg::xlen-1:0]       opB;
	logic [rv32iPkg::xlen-1:0]       aluResult;
	logic                            branchEnable;
	logic                            exIsBranch;

	// the register file is written at the same edge that captures the next instruction,
	// so a dependent instruction one behind has to take the value straight from the ALU
	assign fwdHit   = wrEn && (exRd != '0);
	assign fwdData1 = (fwdHit && (rs1 == exRd)) ? aluResult : rdData1;
	assign fwdData2 = (fwdHit && (rs2 == exRd)) ? aluResult : rdData2;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
		end else begin
			exValid <= inValid; // one instruction per cycle, no stall
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			exPc       <= inPc;
			exRd       <= rd;
			exAluOp    <= aluOp;
			exBranchOp <= branchOp;
			exSrcASel  <= srcASel;
			exUseImm   <= useImm;
			exImm      <= imm;
			exWritesRd <= writesRd;
			exIllegal  <= illegal;
			exRs1Data  <= fwdData1;
			exRs2Data  <= fwdData2;
		end
	end

	////////////////////////////////////////////////////////////
	// operand select and ALU
	////////////////////////////////////////////////////////////

	assign opA = (exSrcASel == rv32iPkg::srcAPc) ? exPc : exRs1Data; // pc only for auipc
	assign opB = exUseImm ? exImm : exRs2Data;

	alu alu_i (
		.aluCtl       (exAluOp),
		.branchOp     (exBranchOp),
		.a            (opA),
		.b            (opB),
		.aluOut       (aluResult),
		.branchEnable (branchEnable)
	);

	assign exIsBranch = (exBranchOp != rv32iPkg::brNone);

	// write port of the register file, only legal instructions that produce a value
	assign wrEn   = exValid && !exIllegal && exWritesRd;
	assign wrAddr = exRd;
	assign wrData = aluResult;

	////////////////////////////////////////////////////////////
	// result register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resValid   <= 1'b0;
			resRd      <= '0;
			resData    <= '0;
			resBranch  <= 1'b0;
			resTarget  <= '0;
			resIllegal <= 1'b0;
		end else begin
			resValid   <= exValid;
			resRd      <= wrEn ? exRd : '0;        // zero for branches, illegal and idle
			resData    <= wrEn ? aluResult : '0;   // the value written to resRd
			resBranch  <= exValid && branchEnable;
			// target only means something for a branch, otherwise it reads zero
			resTarget  <= (exValid && exIsBranch) ? (exPc + exImm) : '0;
			resIllegal <= exValid && exIllegal;
		end
	end

endmodule

/* rtl/rv32iExecTop.sv */
`timescale 1ns/1ps

module rv32iExecTop (
	input  logic            clk,
	input  logic            arstN,
	input  logic            inValid,
	input  logic [31:0]     inInstr,
	input  logic [31:0]     inPc,
	output logic            resValid,
	output logic [4:0]      resRd,
	output logic [31:0]     resData,
	output logic            resBranch,
	output logic [31:0]     resTarget,
	output logic            resIllegal
);

	////////////////////////////////////////////////////////////
	// decode outputs
	////////////////////////////////////////////////////////////

	logic [rv32iPkg::regAddrW-1:0]   rs1;
	logic [rv32iPkg::regAddrW-1:0]   rs2;
	logic [rv32iPkg::regAddrW-1:0]   rd;
	rv32iPkg::aluOpE                 aluOp;
	rv32iPkg::branchOpE              branchOp;
	rv32iPkg::srcASelE               srcASel;
	logic                            useImm;
	logic [rv32iPkg::xlen-1:0]       imm;
	logic                            writesRd;
	logic                            illegal;

	logic [rv32iPkg::xlen-1:0]       rdData1;  // register file read data
	logic [rv32iPkg::xlen-1:0]       rdData2;
	logic                            wrEn;     // write-back from the execute stage
	logic [rv32iPkg::regAddrW-1:0]   wrAddr;
	logic [rv32iPkg::xlen-1:0]       wrData;

	instDecode instDecode_i (
		.instr    (inInstr),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.aluOp    (aluOp),
		.branchOp (branchOp),
		.srcASel  (srcASel),
		.useImm   (useImm),
		.imm      (imm),
		.writesRd (writesRd),
		.illegal  (illegal)
	);

	regFile regFile_i (
		.clk     (clk),
		.arstN   (arstN),
		.rdAddr1 (rs1),
		.rdAddr2 (rs2),
		.rdData1 (rdData1),
		.rdData2 (rdData2),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	executeStage executeStage_i (
		.clk        (clk),
		.arstN      (arstN),
		.inValid    (inValid),
		.inPc       (inPc),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.aluOp      (aluOp),
		.branchOp   (branchOp),
		.srcASel    (srcASel),
		.useImm     (useImm),
		.imm        (imm),
		.writesRd   (writesRd),
		.illegal    (illegal),
		.rdData1    (rdData1),
		.rdData2    (rdData2),
		.wrEn       (wrEn),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.resValid   (resValid),
		.resRd      (resRd),
		.resData    (resData),
		.resBranch  (resBranch),
		.resTarget  (resTarget),
		.resIllegal (resIllegal)
	);

endmodule

/* verification/rv32iExec_sva.sv */
`timescale 1ns/1ps

module rv32iExec_sva (
	input logic                            clk,
	input logic                            arstN,
	input logic                            inValid,
	input logic [rv32iPkg::regAddrW-1:0]   rs1,
	input logic [rv32iPkg::regAddrW-1:0]   rs2,
	input logic [rv32iPkg::xlen-1:0]       exRs1Data,
	input logic [rv32iPkg::xlen-1:0]       exRs2Data,
	input logic                            resValid,
	input logic [rv32iPkg::regAddrW-1:0]   resRd,
	input logic                            resBranch,
	input logic                            resIllegal
);

	int assertFails = 0; // read by tbTop when the run ends

	////////////////////////////////////////////////////////////
	// reset, x0 and result consistency
	////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge clk) !arstN |=> !resValid)
		else begin
			assertFails++;
			$error("resValid high during reset");
		end

	// an x0 source has to arrive as zero, even right behind an instruction that targets x0
	x0Operand1: assert property (@(posedge clk) disable iff (!arstN)
		(inValid && (rs1 == '0)) |=> (exRs1Data == '0))
		else begin
			assertFails++;
			$error("x0 operand 1 did not reach the execute stage as zero");
		end

	x0Operand2: assert property (@(posedge clk) disable iff (!arstN)
		(inValid && (rs2 == '0)) |=> (exRs2Data == '0))
		else begin
			assertFails++;
			$error("x0 operand 2 did not reach the execute stage as zero");
		end

	// one decode-to-execute register and one result register
	latency: assert property (@(posedge clk) disable iff (!arstN) inValid |-> ##2 resValid)
		else begin
			assertFails++;
			$error("resValid did not follow an instruction by 2 cycles");
		end

	noRdOnBranch: assert property (@(posedge clk) (resBranch || resIllegal) |-> (resRd == '0))
		else begin
			assertFails++;
			$error("resRd nonzero on a branch or illegal instruction");
		end

endmodule

bind executeStage rv32iExec_sva sva_i (
	.clk        (clk),
	.arstN      (arstN),
	.inValid    (inValid),
	.rs1        (rs1),
	.rs2        (rs2),
	.exRs1Data  (exRs1Data),
	.exRs2Data  (exRs2Data),
	.resValid   (resValid),
	.resRd      (resRd),
	.resBranch  (resBranch),
	.resIllegal (resIllegal)
);

/* verification/resultChecker.sv */
`timescale 1ns/1ps

module resultChecker (
	input  logic          clk,
	input  logic          arstN,
	input  logic          inValid,
	input  logic          resValid,
	input  logic [4:0]    resRd,
	input  logic [31:0]   resData,
	input  logic          resBranch,
	input  logic [31:0]   resTarget,
	input  logic          resIllegal,
	input  logic          endOfRun,
	output int            errorCount,
	output int            resultCount
);

	localparam int maxRecords = 64;
	localparam int recWords = 6; // hdr, instr, pc, exp, data, target

	logic [31:0] expMem [0:maxRecords*recWords-1];
	int numRecords;
	int cycleNow = 0;      // counts falling edges, where outputs are sampled
	int errors = 0;
	int results = 0;
	int testErrors = 0;
	int testResults = 0;
	int testsDone = 0;
	int acceptQ[$];        // cycle of every accepted instruction, oldest first

	assign errorCount = errors;
	assign resultCount = results;

	initial begin
		$readmemh("verification/rv32iExecTestdata.mem", expMem);
		numRecords = 0;
		while (numRecords < maxRecords && expMem[numRecords*recWords] !== 32'hFFFFFFFF) begin
			numRecords++;
		end
	end

	task automatic checkField(input string name, input int rec, input logic [31:0] got,
	                          input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s in record %0d: got 0x%08h, expected 0x%08h", name, rec, got, exp);
			errors++;
			testErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// one result against the next expected record
	////////////////////////////////////////////////////////////

	task automatic checkRecord(input int rec);
		logic [31:0] exp;
		int testNum;
		int latency;
		exp = expMem[rec*recWords+3];
		testNum = expMem[rec*recWords][15:8];
		if (acceptQ.size() == 0) begin
			$display("result for record %0d arrived with no instruction accepted", rec);
			errors++;
			testErrors++;
		end else begin
			latency = cycleNow - acceptQ.pop_front();
			if (latency != 2) begin
				$display("result for record %0d came %0d cycles after its instruction, not 2",
				         rec, latency);
				errors++;
				testErrors++;
			end
		end
		checkField("resRd", rec, {27'b0, resRd}, {27'b0, exp[12:8]});
		checkField("resData", rec, resData, expMem[rec*recWords+4]);
		checkField("resBranch", rec, {31'b0, resBranch}, {31'b0, exp[1]});
		checkField("resTarget", rec, resTarget, expMem[rec*recWords+5]);
		checkField("resIllegal", rec, {31'b0, resIllegal}, {31'b0, exp[0]});
		testResults++;
		// a test ends at its last record in the file
		if (rec == numRecords - 1 || expMem[(rec+1)*recWords][15:8] != testNum) begin
			$display("test %0d: %0d results, %0d errors", testNum, testResults, testErrors);
			testsDone++;
			testResults = 0;
			testErrors = 0;
		end
	endtask

	always @(negedge clk) begin
		if (arstN) begin
			if (inValid) begin
				acceptQ.push_back(cycleNow); // accepted at the coming rising edge
			end
			if (resValid) begin
				if (results >= numRecords) begin
					$display("a result arrived at cycle %0d after every record was done", cycleNow);
					errors++;
				end else begin
					checkRecord(results);
					results++;
				end
			end
		end
		cycleNow++;
	end

	always @(posedge endOfRun) begin
		if (results < numRecords) begin
			$display("%0d of %0d results never arrived", numRecords - results, numRecords);
			errors++;
		end
		$display("%0d tests, %0d results, %0d errors", testsDone, results, errors);
	end

endmodule

/* verification/tbTop.sv */
`timescale 1ns/1ps

module tbTop;

	localparam int maxRecords = 64;
	localparam int recWords = 6;   // words per record in the data file
	localparam int driveDelay = 2; // inputs change this long after the rising edge

	logic          clk;
	logic          arstN;
	logic          inValid;
	logic [31:0]   inInstr;
	logic [31:0]   inPc;
	logic          resValid;
	logic [4:0]    resRd;
	logic [31:0]   resData;
	logic          resBranch;
	logic [31:0]   resTarget;
	logic          resIllegal;
	logic          endOfRun;
	int            errorCount;
	int            resultCount;

	logic [31:0] stimMem [0:maxRecords*recWords-1];
	logic [31:0] lfsrState;
	int numRecords;
	int cycleCount = 0;
	int cycleLimit;
	int gap;

	always #20 clk = ~clk;

	rv32iExecTop dut_i (
		.clk        (clk),
		.arstN      (arstN),
		.inValid    (inValid),
		.inInstr    (inInstr),
		.inPc       (inPc),
		.resValid   (resValid),
		.resRd      (resRd),
		.resData    (resData),
		.resBranch  (resBranch),
		.resTarget  (resTarget),
		.resIllegal (resIllegal)
	);

	resultChecker checker_i (
		.clk         (clk),
		.arstN       (arstN),
		.inValid     (inValid),
		.resValid    (resValid),
		.resRd       (resRd),
		.resData     (resData),
		.resBranch   (resBranch),
		.resTarget   (resTarget),
		.resIllegal  (resIllegal),
		.endOfRun    (endOfRun),
		.errorCount  (errorCount),
		.resultCount (resultCount)
	);

	////////////////////////////////////////////////////////////
	// idle gap generator
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawGap(output int count);
		count = 0;
		for (int b = 0; b < 2; b++) begin
			lfsrState = lfsrNext(lfsrState); // one step per bit taken
			count = (count << 1) | lfsrState[0];
		end
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, %0d of %0d results seen", cycleCount,
			         resultCount, numRecords);
			endOfRun = 1'b1; // the checker lists the missing results and its counts
			#1;
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		inPc = '0;
		endOfRun = 1'b0;
		lfsrState = 32'h2596;
		$readmemh("verification/rv32iExecTestdata.mem", stimMem);
		numRecords = 0;
		while (numRecords < maxRecords && stimMem[numRecords*recWords] !== 32'hFFFFFFFF) begin
			numRecords++;
		end
		cycleLimit = 4 * (numRecords + 3 * numRecords) + 20; // at most 3 idle cycles per record

		repeat (2) @(posedge clk);
		#driveDelay arstN = 1'b1;

		for (int i = 0; i < numRecords; i++) begin
			gap = 0;
			if (!stimMem[i*recWords][0]) begin
				drawGap(gap); // flagged records follow their predecessor directly
			end
			repeat (gap) begin
				@(posedge clk);
				#driveDelay inValid = 1'b0;
			end
			@(posedge clk);
			#driveDelay;
			inValid = 1'b1;
			inInstr = stimMem[i*recWords+1];
			inPc = stimMem[i*recWords+2];
		end
		@(posedge clk);
		#driveDelay;
		inValid = 1'b0;
		inInstr = '0;
		inPc = '0;

		while (resultCount < numRecords) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk); // room for a stray extra result
		endOfRun = 1'b1;
		#1;
		if (errorCount == 0 && dut_i.executeStage_i.sva_i.assertFails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verification/rv32iExecTestdata.mem */
// hdr (15:8 test number, 0 no idle gap before the record), instr, pc,
// exp (12:8 rd, 1 branch, 0 illegal), data, target
00000100 FFB00093 00000000 00000100 FFFFFFFB 00000000 // addi x1, x0, -5
00000100 5A500113 00000004 00000200 000005A5 00000000 // addi x2, x0, 0x5a5
00000100 401101B3 00000008 00000300 000005AA 00000000 // sub x3, x2, x1
00000100 0020F233 0000000C 00000400 000005A1 00000000 // and x4, x1, x2
00000100 0020E2B3 00000010 00000500 FFFFFFFF 00000000 // or x5, x1, x2
00000100 0020C333 00000014 00000600 FFFFFA5E 00000000 // xor x6, x1, x2
00000100 0020A3B3 00000018 00000700 00000001 00000000 // slt x7, x1, x2
00000100 0020B433 0000001C 00000800 00000000 00000000 // sltu x8, x1, x2
00000100 4010D493 00000020 00000900 FFFFFFFD 00000000 // srai x9, x1, 1
00000100 0020D533 00000024 00000A00 07FFFFFF 00000000 // srl x10, x1, x2 shifts by 5
00000100 001115B3 00000028 00000B00 28000000 00000000 // sll x11, x2, x1 shifts by 27
00000100 FFF13613 0000002C 00000C00 00000001 00000000 // sltiu x12, x2, -1
00000200 876546B7 00000030 00000D00 87654000 00000000 // lui x13, 0x87654
00000200 12345717 00001000 00000E00 12346000 00000000 // auipc x14, 0x12345
00000200 FFFFF797 00002000 00000F00 00001000 00000000 // auipc x15, 0xfffff wraps
00000300 00108863 00000100 00000002 00000000 00000110 // beq x1, x1, +16 taken
00000300 FE209CE3 00000104 00000002 00000000 000000FC // bne x1, x2, -8 taken
00000300 0020C863 00000108 00000002 00000000 00000118 // blt x1, x2, +16 taken
00000300 0020D863 0000010C 00000000 00000000 0000011C // bge x1, x2, +16 not taken
00000300 0020E863 00000110 00000000 00000000 00000120 // bltu x1, x2, +16 not taken
00000300 FE20FCE3 00000114 00000002 00000000 0000010C // bgeu x1, x2, -8 taken
00000400 00700193 00000200 00000300 00000007 00000000 // addi x3, x0, 7
00000401 003181B3 00000204 00000300 0000000E 00000000 // add x3, x3, x3
00000401 00118213 00000208 00000400 0000000F 00000000 // addi x4, x3, 1
00000401 404182B3 0000020C 00000500 FFFFFFFF 00000000 // sub x5, x3, x4
00000401 00528013 00000210 00000000 00000004 00000000 // addi x0, x5, 5
00000401 00500333 00000214 00000600 FFFFFFFF 00000000 // add x6, x0, x5
00000500 00012083 00000300 00000001 00000000 00000000 // lw x1, 0(x2)
00000500 000000EF 00000304 00000001 00000000 00000000 // jal x1, 0
00000500 021080B3 00000308 00000001 00000000 00000000 // mul x1, x1, x1
00000501 00008393 0000030C 00000700 FFFFFFFB 00000000 // addi x7, x1, 0 sees old x1
FFFFFFFF 00000000 00000000 00000000 00000000 00000000 // end of records

/* vlog.f */
rtl/rv32iPkg.sv
rtl/instDecode.sv
rtl/alu.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/rv32iExecTop.sv
verification/rv32iExec_sva.sv
verification/resultChecker.sv
verification/tbTop.sv
